// File: dcache.f
design/dcache_pkg.sv
design/sdp_ram.sv
design/dcache_tagv.sv
design/dcache_ctrl.sv
design/dcache_top.sv
test/dcache_mem_model.sv
test/dcache_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the dcache testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module dcache_tb -Mdir obj_dir -f dcache.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vdcache_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test OK$" "$log"; then
    exit 0
fi
echo "pass line not found in $log"
exit 1

// File: test/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    localparam int random_reqs = 200;
    localparam int total_reqs  = 15 + random_reqs;
    localparam int timeout_cyc = total_reqs * 40 + 200;

    // one request in flight, as the compare side sees it
    typedef struct packed {
        logic        write;
        logic        miss;
        addr_t       addr;
        word_t       data;
        logic [31:0] acc;
    } expect_t;

    logic     clk;
    logic     rst;
    logic     req;
    cpu_req_t req_data;
    logic     ready;
    logic     resp_valid;
    word_t    rdata;
    logic     mem_rd_req;
    addr_t    mem_rd_addr;
    logic     mem_rd_valid;
    word_t    mem_rd_data;
    logic     mem_wr_req;
    mem_wr_t  mem_wr;
    logic     mem_wr_done;

    // expected memory contents, written words only
    word_t   mem_ref [addr_t];
    // cache model: valid, tag and the way to replace next
    logic    c_valid [num_ways][num_sets];
    tag_t    c_tag [num_ways][num_sets];
    logic    c_lru [num_sets];
    expect_t exp_q [$];

    int cycle = 0;
    int errors = 0;
    int checks = 0;
    int rd_count = 0;
    int pred_misses = 0;
    int rd_since_resp = 0;
    int wr_since_resp = 0;
    logic rd_req_q = 1'b0;
    logic wr_req_q = 1'b0;

    dcache_top dut0 (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .req_data     (req_data),
        .ready        (ready),
        .resp_valid   (resp_valid),
        .rdata        (rdata),
        .mem_rd_req   (mem_rd_req),
        .mem_rd_addr  (mem_rd_addr),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_data  (mem_rd_data),
        .mem_wr_req   (mem_wr_req),
        .mem_wr       (mem_wr),
        .mem_wr_done  (mem_wr_done)
    );

    dcache_mem_model mem0 (
        .clk          (clk),
        .mem_rd_req   (mem_rd_req),
        .mem_rd_addr  (mem_rd_addr),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_data  (mem_rd_data),
        .mem_wr_req   (mem_wr_req),
        .mem_wr       (mem_wr),
        .mem_wr_done  (mem_wr_done)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    // power-on memory contents
    function automatic word_t initial_word(input addr_t a);
        return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b1);
    endfunction

    function automatic word_t expected_read(input addr_t a);
        addr_t w;
        w = {a[31:2], 2'b00};
        if (mem_ref.exists(w)) begin
            return mem_ref[w];
        end
        return initial_word(w);
    endfunction

    // one lru bit per set, hit points away from the hit way
    // returns 1 when a read has to refill
    function automatic logic model_access(input logic wr, input addr_t a);
        tag_t   t;
        index_t i;
        logic   found;
        logic   way;
        t     = a[addr_bits-1 -: tag_bits];
        i     = a[byte_bits+offset_bits +: index_bits];
        found = 1'b0;
        way   = 1'b0;
        for (int w = 0; w < num_ways; w++) begin
            if (c_valid[w][i] && c_tag[w][i] == t) begin
                found = 1'b1;
                way   = w[0];
            end
        end
        if (found) begin
            c_lru[i] = ~way;
        end else if (!wr) begin
            // read miss fills the lru way, write miss leaves the set alone
            way             = c_lru[i];
            c_valid[way][i] = 1'b1;
            c_tag[way][i]   = t;
            c_lru[i]        = ~way;
        end
        return !found && !wr;
    endfunction

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////

    task automatic issue_req(input logic wr, input addr_t a, input word_t d);
        expect_t e;
        do begin
            @(posedge clk);
        end while (!ready);
        req      <= 1'b1;
        req_data <= '{write: wr, addr: a, data: d};
        // dut takes it on this edge
        @(posedge clk);
        req     <= 1'b0;
        e.write = wr;
        e.addr  = a;
        e.data  = wr ? d : expected_read(a);
        e.miss  = model_access(wr, a);
        e.acc   = cycle;
        if (wr) begin
            mem_ref[{a[31:2], 2'b00}] = d;
        end
        if (e.miss) begin
            pred_misses++;
        end
        exp_q.push_back(e);
    endtask

    task automatic finish_test(input string name, input int n, input int err0);
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        $display("%-26s %0d requests, %0d errors", name, n, errors - err0);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        assert (got == want)
        else begin
            errors++;
            $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, want);
        end
    endtask

    ////////////////////////////////////////
    // monitors and compare
    ////////////////////////////////////////

    always @(posedge clk) begin
        expect_t e;
        if (rst) begin
            rd_req_q = 1'b0;
            wr_req_q = 1'b0;
        end else begin
            // refill start, line base plus critical offset
            if (mem_rd_req && !rd_req_q) begin
                rd_count++;
                rd_since_resp++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("refill started with no request in flight at %0t", $time);
                end else begin
                    check_value("mem_rd_addr", mem_rd_addr, {exp_q[0].addr[31:2], 2'b00});
                end
            end
            // write-through start
            if (mem_wr_req && !wr_req_q) begin
                wr_since_resp++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("memory write with no request in flight at %0t", $time);
                end else begin
                    check_value("mem_wr.addr", mem_wr.addr, exp_q[0].addr);
                    check_value("mem_wr.data", mem_wr.data, exp_q[0].data);
                end
            end
            if (resp_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("response with no request in flight at %0t", $time);
                end else begin
                    e = exp_q.pop_front();
                    if (!e.write) begin
                        check_value("rdata", rdata, e.data);
                    end
                    check_value("mem_rd_req starts", rd_since_resp, e.miss ? 1 : 0);
                    check_value("mem_wr_req starts", wr_since_resp, e.write ? 1 : 0);
                    // resp_valid rose on the edge before this one
                    if (!e.write && !e.miss) begin
                        check_value("hit latency", cycle - e.acc - 1, 2);
                    end
                end
                rd_since_resp = 0;
                wr_since_resp = 0;
            end
            rd_req_q = mem_rd_req;
            wr_req_q = mem_wr_req;
        end
    end

    // watchdog, scaled to the request count
    initial begin
        repeat (timeout_cyc) @(posedge clk);
        $display("watchdog expired after %0d cycles, cache stopped responding", timeout_cyc);
        $display("Test FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        int    err0;
        int    rd0;
        int    pm0;
        addr_t a;
        logic  wr;
        void'($urandom(32'h7bba_bb8e));
        rst      = 1'b1;
        req      = 1'b0;
        req_data = '0;
        for (int w = 0; w < num_ways; w++) begin
            for (int s = 0; s < num_sets; s++) begin
                c_valid[w][s] = 1'b0;
                c_tag[w][s]   = '0;
            end
        end
        for (int s = 0; s < num_sets; s++) begin
            c_lru[s] = 1'b0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checks++;
        assert (ready && !resp_valid && !mem_rd_req && !mem_wr_req)
        else begin
            errors++;
            $display("outputs not in their idle state after reset at %0t", $time);
        end

        // critical offset 1, index 3
        err0 = errors;
        issue_req(1'b0, 32'h0000_1234, '0);
        finish_test("cold read miss", 1, err0);

        err0 = errors;
        for (int k = 0; k < words_per_line; k++) begin
            issue_req(1'b0, 32'h0000_1230 + addr_t'(4 * k), '0);
        end
        finish_test("read hits", words_per_line, err0);

        err0 = errors;
        issue_req(1'b1, 32'h0000_1238, 32'hdead_beef);
        issue_req(1'b0, 32'h0000_1238, '0);
        finish_test("write-through on hit", 2, err0);

        err0 = errors;
        issue_req(1'b1, 32'h0000_5678, 32'h1357_9bdf);
        issue_req(1'b0, 32'h0000_5678, '0);
        finish_test("write miss no allocate", 2, err0);

        // three tags on set 11: A B A C, then A hits and B refills
        err0 = errors;
        issue_req(1'b0, 32'h0001_00b0, '0);
        issue_req(1'b0, 32'h0002_00b4, '0);
        issue_req(1'b0, 32'h0001_00b0, '0);
        issue_req(1'b0, 32'h0003_00b8, '0);
        issue_req(1'b0, 32'h0001_00b0, '0);
        issue_req(1'b0, 32'h0002_00b4, '0);
        finish_test("lru replacement", 6, err0);

        // four tags over four sets keeps both ways busy
        err0 = errors;
        rd0  = rd_count;
        pm0  = pred_misses;
        for (int n = 0; n < random_reqs; n++) begin
            a  = 32'h0040_0000
               | (addr_t'($urandom_range(0, 3)) << 8)
               | (addr_t'($urandom_range(0, 3)) << 4)
               | (addr_t'($urandom_range(0, 3)) << 2);
            wr = ($urandom_range(0, 9) < 3);
            issue_req(wr, a, $urandom());
        end
        finish_test("random mix", random_reqs, err0);
        check_value("refill count", rd_count - rd0, pred_misses - pm0);

        $display("checks %0d, errors %0d, refills %0d", checks, errors, rd_count);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/dcache_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_mem_model (
    input  wire                      clk,
    // line refill
    input  wire                      mem_rd_req,
    input  wire dcache_pkg::addr_t   mem_rd_addr,
    output logic                     mem_rd_valid,
    output dcache_pkg::word_t        mem_rd_data,
    // write-through
    input  wire                      mem_wr_req,
    input  wire dcache_pkg::mem_wr_t mem_wr,
    output logic                     mem_wr_done
);
    import dcache_pkg::*;

    // words written so far, anything else reads the fill pattern
    word_t shadow [addr_t];

    // fill pattern, mixes every address bit
    function automatic word_t initial_word(input addr_t a);
        return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b1);
    endfunction

    function automatic word_t read_word(input addr_t a);
        word_t w;
        if (shadow.exists(a)) begin
            w = shadow[a];
        end else begin
            w = initial_word(a);
        end
        return w;
    endfunction

    initial begin
        addr_t   base;
        addr_t   beat_addr;
        offset_t off;
        mem_wr_t wr;
        int      delay;
        mem_rd_valid = 1'b0;
        mem_rd_data  = '0;
        mem_wr_done  = 1'b0;
        forever begin
            @(posedge clk);
            if (mem_rd_req) begin
                base  = mem_rd_addr;
                delay = $urandom_range(1, 5);
                repeat (delay - 1) @(posedge clk);
                // beats back to back, wrapping from the critical word
                for (int k = 0; k < words_per_line; k++) begin
                    off          = base[3:2] + offset_t'(k);
                    beat_addr    = {base[31:4], off, 2'b00};
                    mem_rd_valid <= 1'b1;
                    mem_rd_data  <= read_word(beat_addr);
                    @(posedge clk);
                end
                mem_rd_valid <= 1'b0;
            end else if (mem_wr_req) begin
                wr    = mem_wr;
                delay = $urandom_range(1, 5);
                repeat (delay - 1) @(posedge clk);
                shadow[wr.addr] = wr.data;
                mem_wr_done     <= 1'b1;
                @(posedge clk);
                mem_wr_done <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  wire                       clk,
    input  wire                       rst,
    // processor side
    input  wire                       req,
    input  wire dcache_pkg::cpu_req_t req_data,
    output logic                      ready,
    output logic                      resp_valid,
    output dcache_pkg::word_t         rdata,
    // memory read, line refill
    output logic                      mem_rd_req,
    output dcache_pkg::addr_t         mem_rd_addr,
    input  wire                       mem_rd_valid,
    input  wire dcache_pkg::word_t    mem_rd_data,
    // memory write-through
    output logic                      mem_wr_req,
    output dcache_pkg::mem_wr_t       mem_wr,
    input  wire                       mem_wr_done
);
    import dcache_pkg::*;

    // tag/valid array links
    index_t     lookup_index;
    tag_t       lookup_tag;
    way_mask_t  hit;
    index_t     fill_index;
    tag_t       fill_tag;
    way_mask_t  fill_we;

    // data ram links, shared by both ways
    data_addr_t data_raddr;
    data_addr_t data_waddr;
    word_t      data_wdata;
    way_mask_t  data_we;
    word_t      way0_rdata;
    word_t      way1_rdata;

    ////////////////////////////////////////
    // tags and valid bits
    ////////////////////////////////////////

    dcache_tagv tagv0 (
        .clk          (clk),
        .rst          (rst),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .hit          (hit),
        .fill_index   (fill_index),
        .fill_tag     (fill_tag),
        .fill_we      (fill_we)
    );

    ////////////////////////////////////////
    // data rams, one per way
    ////////////////////////////////////////

    sdp_ram #(
        .data_width ($bits(word_t)),
        .addr_width ($bits(data_addr_t))
    ) data_way0 (
        .clk   (clk),
        .we    (data_we[0]),
        .waddr (data_waddr),
        .din   (data_wdata),
        .raddr (data_raddr),
        .dout  (way0_rdata)
    );

    sdp_ram #(
        .data_width ($bits(word_t)),
        .addr_width ($bits(data_addr_t))
    ) data_way1 (
        .clk   (clk),
        .we    (data_we[1]),
        .waddr (data_waddr),
        .din   (data_wdata),
        .raddr (data_raddr),
        .dout  (way1_rdata)
    );

    // controller
    dcache_ctrl ctrl0 (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .req_data     (req_data),
        .ready        (ready),
        .resp_valid   (resp_valid),
        .rdata        (rdata),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .hit          (hit),
        .fill_index   (fill_index),
        .fill_tag     (fill_tag),
        .fill_we      (fill_we),
        .data_raddr   (data_raddr),
        .data_waddr   (data_waddr),
        .data_wdata   (data_wdata),
        .data_we      (data_we),
        .way0_rdata   (way0_rdata),
        .way1_rdata   (way1_rdata),
        .mem_rd_req   (mem_rd_req),
        .mem_rd_addr  (mem_rd_addr),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_data  (mem_rd_data),
        .mem_wr_req   (mem_wr_req),
        .mem_wr       (mem_wr),
        .mem_wr_done  (mem_wr_done)
    );

endmodule

`default_nettype wire

// File: design/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
    input  wire                         clk,
    input  wire                         rst,
    // processor side
    input  wire                         req,
    input  wire dcache_pkg::cpu_req_t   req_data,
    output logic                        ready,
    output logic                        resp_valid,
    output dcache_pkg::word_t           rdata,
    // tag/valid array
    output dcache_pkg::index_t          lookup_index,
    output dcache_pkg::tag_t            lookup_tag,
    input  wire dcache_pkg::way_mask_t  hit,
    output dcache_pkg::index_t          fill_index,
    output dcache_pkg::tag_t            fill_tag,
    output dcache_pkg::way_mask_t       fill_we,
    // data rams
    output dcache_pkg::data_addr_t      data_raddr,
    output dcache_pkg::data_addr_t      data_waddr,
    output dcache_pkg::word_t           data_wdata,
    output dcache_pkg::way_mask_t       data_we,
    input  wire dcache_pkg::word_t      way0_rdata,
    input  wire dcache_pkg::word_t      way1_rdata,
    // memory side
    output logic                        mem_rd_req,
    output dcache_pkg::addr_t           mem_rd_addr,
    input  wire                         mem_rd_valid,
    input  wire dcache_pkg::word_t      mem_rd_data,
    output logic                        mem_wr_req,
    output dcache_pkg::mem_wr_t         mem_wr,
    input  wire                         mem_wr_done
);
    import dcache_pkg::*;

    ctrl_state_t         state;
    // first lookup cycle, tag ram read still in flight
    logic                lookup_wait;
    cpu_req_t            req_q;
    offset_t             beat_cnt;
    // way to replace next, per set
    logic [num_sets-1:0] lru;
    logic                victim;
    way_mask_t           victim_mask;
    // hit way of a write, cleared after its data ram write
    way_mask_t           wr_hit;
    logic                last_beat;
    logic                eval;

    tag_t                req_tag;
    index_t              req_index;
    offset_t             req_offset;
    offset_t             fill_offset;
    word_t               hit_word;

    // address fields of the held request
    assign req_offset = req_q.addr[byte_bits +: offset_bits];
    assign req_index  = req_q.addr[byte_bits+offset_bits +: index_bits];
    assign req_tag    = req_q.addr[addr_bits-1 -: tag_bits];

    // beats arrive critical word first, wrap within the line
    assign fill_offset = req_offset + beat_cnt;
    assign last_beat   = (beat_cnt == offset_t'(words_per_line - 1));
    assign victim_mask = way_mask_t'(1) << victim;
    assign eval        = (state == lookup) && !lookup_wait;
    assign hit_word    = hit[1] ? way1_rdata : way0_rdata;

    ////////////////////////////////////////
    // fsm
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= idle;
            lookup_wait <= 1'b0;
            beat_cnt    <= '0;
            victim      <= 1'b0;
            wr_hit      <= '0;
            lru         <= '0;
        end else begin
            case (state)
                idle: begin
                    if (req) begin
                        state       <= lookup;
                        lookup_wait <= 1'b1;
                    end
                end
                lookup: begin
                    lookup_wait <= 1'b0;
                    if (!lookup_wait) begin
                        // a hit points the set at the other way
                        if (|hit) begin
                            lru[req_index] <= hit[0];
                        end
                        if (req_q.write) begin
                            wr_hit <= hit;
                            state  <= write_mem;
                        end else if (|hit) begin
                            state <= respond;
                        end else begin
                            victim   <= lru[req_index];
                            beat_cnt <= '0;
                            state    <= refill;
                        end
                    end
                end
                refill: begin
                    if (mem_rd_valid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat) begin
                            lru[req_index] <= ~victim;
                            state          <= refill_done;
                        end
                    end
                end
                refill_done: begin
                    state <= respond;
                end
                write_mem: begin
                    wr_hit <= '0;
                    if (mem_wr_done) begin
                        state <= respond;
                    end
                end
                respond: begin
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // request and response payload
    always_ff @(posedge clk) begin
        if (ready && req) begin
            req_q <= req_data;
        end
        if (eval) begin
            rdata <= req_q.write ? req_q.data : hit_word;
        end
        // critical word is beat zero
        if (state == refill && mem_rd_valid && beat_cnt == '0) begin
            rdata <= mem_rd_data;
        end
    end

    ////////////////////////////////////////
    // outputs
    ////////////////////////////////////////

    assign ready      = (state == idle);
    assign resp_valid = (state == respond);

    assign lookup_index = req_index;
    assign lookup_tag   = req_tag;
    assign fill_index   = req_index;
    assign fill_tag     = req_tag;
    // tag goes in with the last beat only
    assign fill_we      = (state == refill && mem_rd_valid && last_beat) ? victim_mask : '0;

    assign data_raddr = {req_index, req_offset};
    assign data_waddr = {req_index, (state == refill) ? fill_offset : req_offset};
    assign data_wdata = (state == refill) ? mem_rd_data : req_q.data;

    always_comb begin
        data_we = '0;
        if (state == refill && mem_rd_valid) begin
            data_we = victim_mask;
        end else if (state == write_mem) begin
            data_we = wr_hit;
        end
    end

    assign mem_rd_req  = (state == refill);
    assign mem_rd_addr = {req_q.addr[addr_bits-1:byte_bits], {byte_bits{1'b0}}};
    assign mem_wr_req  = (state == write_mem);
    assign mem_wr      = '{addr: req_q.addr, data: req_q.data};

    // one memory transaction at a time
    a_mem_excl: assert property (@(posedge clk) disable iff (rst) !(mem_rd_req && mem_wr_req));

    a_resp_pulse: assert property (@(posedge clk) disable iff (rst) resp_valid |=> !resp_valid);

endmodule

`default_nettype wire

// File: design/dcache_tagv.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tagv (
    input  wire                        clk,
    input  wire                        rst,
    // lookup port, hit follows one cycle later
    input  wire dcache_pkg::index_t    lookup_index,
    input  wire dcache_pkg::tag_t      lookup_tag,
    output dcache_pkg::way_mask_t      hit,
    // fill port, one way at a time
    input  wire dcache_pkg::index_t    fill_index,
    input  wire dcache_pkg::tag_t      fill_tag,
    input  wire dcache_pkg::way_mask_t fill_we
);
    import dcache_pkg::*;

    // stored tag per way, registered ram output
    tag_t   way_tag [num_ways];
    // valid bit per set, one vector per way
    logic [num_ways-1:0][num_sets-1:0] valid;
    // index of the read in flight
    index_t index_q;

    ////////////////////////////////////////
    // tag rams
    ////////////////////////////////////////

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        sdp_ram #(
            .data_width ($bits(tag_t)),
            .addr_width ($bits(index_t))
        ) tag_ram (
            .clk   (clk),
            .we    (fill_we[w]),
            .waddr (fill_index),
            .din   (fill_tag),
            .raddr (lookup_index),
            .dout  (way_tag[w])
        );

        // tag match only counts on a valid line
        assign hit[w] = valid[w][index_q] && (way_tag[w] == lookup_tag);
    end

    ////////////////////////////////////////
    // valid bits
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else begin
            for (int w = 0; w < num_ways; w++) begin
                if (fill_we[w]) begin
                    valid[w][fill_index] <= 1'b1;
                end
            end
        end
    end

    // line the valid read up with the ram read
    always_ff @(posedge clk) begin
        index_q <= lookup_index;
    end

    // a line lives in at most one way
    a_hit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(hit));

    // refill targets a single victim way
    a_fill_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(fill_we));

endmodule

`default_nettype wire

// File: design/sdp_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sdp_ram #(
    parameter int data_width = 32,
    parameter int addr_width = 6
) (
    input  wire                   clk,
    input  wire                   we,
    input  wire  [addr_width-1:0] waddr,
    input  wire  [data_width-1:0] din,
    input  wire  [addr_width-1:0] raddr,
    output logic [data_width-1:0] dout
);

    // storage, no reset so it maps onto block ram
    logic [data_width-1:0] mem [0:(1<<addr_width)-1];

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= din;
        end
    end

    // registered read, old data on a same-address collision
    always_ff @(posedge clk) begin
        dout <= mem[raddr];
    end

    // both addresses must be known whenever a write lands
    a_addr_known: assert property (@(posedge clk) we |-> !$isunknown({waddr, raddr}));

endmodule

`default_nettype wire

// File: design/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    ////////////////////////////////////////
    // geometry
    ////////////////////////////////////////

    localparam int addr_bits   = 32;
    localparam int word_bits   = 32;
    // byte select within a word, word select within a line
    localparam int byte_bits   = 2;
    localparam int offset_bits = 2;
    localparam int index_bits  = 4;
    localparam int tag_bits    = addr_bits - index_bits - offset_bits - byte_bits;

    localparam int num_ways       = 2;
    localparam int num_sets       = 1 << index_bits;
    localparam int words_per_line = 1 << offset_bits;

    ////////////////////////////////////////
    // field types
    ////////////////////////////////////////

    typedef logic [addr_bits-1:0]   addr_t;
    typedef logic [word_bits-1:0]   word_t;
    typedef logic [tag_bits-1:0]    tag_t;
    typedef logic [index_bits-1:0]  index_t;
    typedef logic [offset_bits-1:0] offset_t;
    typedef logic [num_ways-1:0]    way_mask_t;
    // data ram address is {index, word offset}
    typedef logic [index_bits+offset_bits-1:0] data_addr_t;

    // one processor request
    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t data;
    } cpu_req_t;

    // one write-through beat to memory
    typedef struct packed {
        addr_t addr;
        word_t data;
    } mem_wr_t;

    typedef enum logic [2:0] {
        idle,
        lookup,
        refill,
        refill_done,
        write_mem,
        respond
    } ctrl_state_t;

endpackage

`default_nettype wire
